/* design/rp_params.svh */
// Shared widths and timing constants; RP_SYNC_STAGES must be at least 2 and RP_DAC_W below RP_ADC_W
`ifndef RP_PARAMS_SVH
`define RP_PARAMS_SVH

//////////////////////////////
// Sample widths
//////////////////////////////

`define RP_ADC_W        16   // ADC word incl. sign
`define RP_DAC_W        14   // DAC word incl. sign
`define RP_EXP_W        8    // Pins per expansion bank

//////////////////////////////
// Timing
//////////////////////////////

`define RP_RST_MAX      64   // Core reset cycles after PLL lock
`define RP_LOOP_SHIFT   2    // Loopback DAC to ADC scaling
`define RP_SYNC_STAGES  2    // External trigger flop chain

`endif

/* design/rp_dsp_pkg.sv */
// Sample types for the ADC and DAC paths; all samples are two's complement except dac_code_t
`default_nettype none

package rp_dsp_pkg;

  `include "rp_params.svh"

  //////////////////////////////
  // Single samples
  //////////////////////////////

  typedef logic signed [`RP_ADC_W-1:0] adc_sample_t;  // ADC word
  typedef logic signed [`RP_DAC_W-1:0] dac_sample_t;  // DAC word before coding
  typedef logic        [`RP_DAC_W-1:0] dac_code_t;    // Neg slope offset binary

  //////////////////////////////
  // Channel pairs
  //////////////////////////////

  typedef struct packed {
    adc_sample_t a;      // CH 1
    adc_sample_t b;      // CH 2
    logic        valid;  // Per cycle level, no handshake
  } adc_pair_t;

  typedef struct packed {
    dac_sample_t a;  // CH 1
    dac_sample_t b;  // CH 2
  } dac_pair_t;

  typedef struct packed {
    dac_code_t a;  // Pin code CH 1
    dac_code_t b;  // Pin code CH 2
  } dac_code_pair_t;

endpackage

`default_nettype wire

/* design/rp_io_pkg.sv */
// Expansion connector and trigger types; oe high means the pin drives
`default_nettype none

package rp_io_pkg;

  `include "rp_params.svh"

  // One expansion bank as requested by housekeeping
  typedef struct packed {
    logic [`RP_EXP_W-1:0] dat;  // Output level
    logic [`RP_EXP_W-1:0] oe;   // 1 = output enable
  } exp_bank_t;

  // Trigger routing to the N bank
  typedef struct packed {
    logic out_en;   // Trigger takes N pin 0
    logic src_asg;  // 1 = generator, 0 = scope
  } trig_cfg_t;

endpackage

`default_nettype wire

/* design/reset_seq.sv */
// Core reset stretcher; a lock edge that arrives while rst_n_i is low is not stretched
`timescale 1ns/100ps
`default_nettype none

module reset_seq (
  input  logic adc_clk,
  input  logic rst_n_i,       // Board reset, async active low
  input  logic pll_locked_i,  // PLL lock status
  output logic core_rstn_o    // Core reset, active low
);

  `include "rp_params.svh"

  localparam int RST_MAX = `RP_RST_MAX;
  localparam int CNT_W   = $clog2(RST_MAX + 1);

  logic             locked_q;   // Lock delayed by one cycle
  logic             lock_rise;  // Lock edge seen this cycle
  logic [CNT_W-1:0] rst_cnt;    // Nonzero while stretching

  assign lock_rise = pll_locked_i & ~locked_q;

  //////////////////////////////
  // Lock edge and counter
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      locked_q    <= 1'b1;  // Steady lock over reset gives no pulse
      rst_cnt     <= '0;
      core_rstn_o <= 1'b0;
    end else begin
      locked_q <= pll_locked_i;
      if (!pll_locked_i) begin
        rst_cnt <= '0;  // Lost lock aborts without reset
      end else if (lock_rise || (rst_cnt != '0)) begin
        if (rst_cnt < CNT_W'(RST_MAX))
          rst_cnt <= rst_cnt + 1'b1;
        else
          rst_cnt <= '0;  // Wrap back to idle
      end
      core_rstn_o <= (rst_cnt == '0);  // Low one cycle after counter
    end
  end

endmodule

`default_nettype wire

/* design/adc_input_stage.sv */
// ADC sample register; loopback samples are widened by sign extension then shifted up
`timescale 1ns/100ps
`default_nettype none

module adc_input_stage import rp_dsp_pkg::*; (
  input  logic      adc_clk,
  input  logic      core_rstn_i,     // Core reset, async active low
  input  adc_pair_t adc_raw_i,       // Deserialized ADC pair
  input  dac_pair_t loop_i,          // Saturated DAC pair
  input  logic      digital_loop_i,  // 1 = replace ADC with DAC
  output adc_pair_t adc_o
);

  `include "rp_params.svh"

  localparam int ADC_W = `RP_ADC_W;
  localparam int DAC_W = `RP_DAC_W;
  localparam int SHIFT = `RP_LOOP_SHIFT;

  adc_sample_t a_q, b_q;  // Channel registers
  logic        valid_q;
  adc_pair_t   adc_d;     // Register input

  // DAC word to ADC scale
  function automatic adc_sample_t loop_ext(input dac_sample_t s);
    adc_sample_t ext;
    ext = {{(ADC_W-DAC_W){s[DAC_W-1]}}, s};
    return ext <<< SHIFT;
  endfunction

  //////////////////////////////
  // Source select
  //////////////////////////////

  always_comb begin
    if (digital_loop_i) begin
      adc_d.a     = loop_ext(loop_i.a);
      adc_d.b     = loop_ext(loop_i.b);
      adc_d.valid = 1'b1;  // Loop data valid every cycle
    end else begin
      adc_d = adc_raw_i;
    end
  end

  always_ff @(posedge adc_clk) begin
    a_q <= adc_d.a;
    b_q <= adc_d.b;
  end

  always_ff @(posedge adc_clk or negedge core_rstn_i) begin
    if (!core_rstn_i)
      valid_q <= 1'b0;
    else
      valid_q <= adc_d.valid;
  end

  assign adc_o = '{a: a_q, b: b_q, valid: valid_q};

endmodule

`default_nettype wire

/* design/dac_mixer.sv */
// Generator plus controller per channel; sat_o is combinational, dac_o one cycle later
`timescale 1ns/100ps
`default_nettype none

module dac_mixer import rp_dsp_pkg::*; (
  input  logic           adc_clk,
  input  logic           core_rstn_i,  // Core reset, async active low
  input  dac_pair_t      asg_i,        // Generator pair
  input  dac_pair_t      pid_i,        // Controller pair
  output dac_pair_t      sat_o,        // Saturated sum, same cycle
  output dac_code_pair_t dac_o         // Registered pin code
);

  `include "rp_params.svh"

  localparam int W = `RP_DAC_W;

  //////////////////////////////
  // Sum and saturation
  //////////////////////////////

  // One guard bit catches overflow
  function automatic dac_sample_t sat_add(input dac_sample_t x, input dac_sample_t y);
    logic [W:0] sum;
    sum = {x[W-1], x} + {y[W-1], y};
    if (sum[W] ^ sum[W-1])
      return {sum[W], {(W-1){~sum[W]}}};  // Clamp to limit of sum sign
    else
      return sum[W-1:0];
  endfunction

  // Keep sign, invert magnitude bits
  function automatic dac_code_t to_code(input dac_sample_t s);
    return {s[W-1], ~s[W-2:0]};
  endfunction

  assign sat_o.a = sat_add(asg_i.a, pid_i.a);
  assign sat_o.b = sat_add(asg_i.b, pid_i.b);

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge core_rstn_i) begin
    if (!core_rstn_i) begin
      dac_o <= '0;
    end else begin
      dac_o.a <= to_code(sat_o.a);
      dac_o.b <= to_code(sat_o.b);
    end
  end

endmodule

`default_nettype wire

/* design/exp_pin_mux.sv */
// Expansion pin mux; only N pin 0 has an alternate function and only P input 0 is synchronized
`timescale 1ns/100ps
`default_nettype none

module exp_pin_mux import rp_io_pkg::*; (
  input  logic                 adc_clk,
  input  logic                 core_rstn_i,   // Core reset, async active low
  input  exp_bank_t            hk_p_i,        // Housekeeping P request
  input  exp_bank_t            hk_n_i,        // Housekeeping N request
  input  logic [`RP_EXP_W-1:0] exp_p_in_i,    // P pin levels
  input  trig_cfg_t            trig_cfg_i,
  input  logic                 scope_trig_i,  // Scope trigger pulse
  input  logic                 asg_trig_i,    // Generator trigger pulse
  output exp_bank_t            exp_p_o,
  output exp_bank_t            exp_n_o,
  output logic                 trig_ext_o     // Synchronized external trigger
);

  `include "rp_params.svh"

  localparam int SYNC = `RP_SYNC_STAGES;

  logic            trig_sel;  // Chosen trigger source
  logic [SYNC-1:0] sync_q;    // Trigger flop chain

  //////////////////////////////
  // Pin outputs
  //////////////////////////////

  assign exp_p_o  = hk_p_i;  // No alternate function on P
  assign trig_sel = trig_cfg_i.src_asg ? asg_trig_i : scope_trig_i;

  always_comb begin
    exp_n_o = hk_n_i;
    if (trig_cfg_i.out_en) begin
      exp_n_o.dat[0] = trig_sel;
      exp_n_o.oe[0]  = 1'b1;  // Trigger pin always drives
    end
  end

  //////////////////////////////
  // External trigger sync
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge core_rstn_i) begin
    if (!core_rstn_i)
      sync_q <= '0;
    else
      sync_q <= {sync_q[SYNC-2:0], exp_p_in_i[0]};  // Pin 0 is the trigger input
  end

  assign trig_ext_o = sync_q[SYNC-1];

endmodule

`default_nettype wire

/* design/rp_analog_core.sv */
// Signal conditioning core on adc_clk only; every block except reset_seq runs on core_rstn_o
`timescale 1ns/100ps
`default_nettype none

module rp_analog_core import rp_dsp_pkg::*, rp_io_pkg::*; (
  input  logic                 adc_clk,
  input  logic                 rst_n_i,         // Board reset, async active low
  input  logic                 pll_locked_i,
  // ADC and DAC
  input  adc_pair_t            adc_raw_i,       // Deserialized ADC pair
  input  logic                 digital_loop_i,  // 1 = DAC looped into ADC
  input  dac_pair_t            asg_i,           // Generator samples
  input  dac_pair_t            pid_i,           // Controller samples
  // Expansion connector
  input  exp_bank_t            hk_p_i,
  input  exp_bank_t            hk_n_i,
  input  logic [`RP_EXP_W-1:0] exp_p_in_i,
  input  trig_cfg_t            trig_cfg_i,
  input  logic                 scope_trig_i,
  input  logic                 asg_trig_i,
  // Outputs
  output logic                 core_rstn_o,     // Stretched core reset
  output adc_pair_t            adc_o,
  output dac_code_pair_t       dac_o,
  output exp_bank_t            exp_p_o,
  output exp_bank_t            exp_n_o,
  output logic                 trig_ext_o
);

  `include "rp_params.svh"

  dac_pair_t dac_sat;  // Mixer result for loopback

  //////////////////////////////
  // Reset
  //////////////////////////////

  reset_seq i_reset_seq (
    .adc_clk      (adc_clk     ),
    .rst_n_i      (rst_n_i     ),
    .pll_locked_i (pll_locked_i),
    .core_rstn_o  (core_rstn_o )
  );

  //////////////////////////////
  // DAC and ADC paths
  //////////////////////////////

  dac_mixer i_dac_mixer (
    .adc_clk     (adc_clk    ),
    .core_rstn_i (core_rstn_o),
    .asg_i       (asg_i      ),
    .pid_i       (pid_i      ),
    .sat_o       (dac_sat    ),
    .dac_o       (dac_o      )
  );

  adc_input_stage i_adc_input_stage (
    .adc_clk        (adc_clk       ),
    .core_rstn_i    (core_rstn_o   ),
    .adc_raw_i      (adc_raw_i     ),
    .loop_i         (dac_sat       ),  // Loop taps pre register sum
    .digital_loop_i (digital_loop_i),
    .adc_o          (adc_o         )
  );

  //////////////////////////////
  // Expansion pins
  //////////////////////////////

  exp_pin_mux i_exp_pin_mux (
    .adc_clk      (adc_clk     ),
    .core_rstn_i  (core_rstn_o ),
    .hk_p_i       (hk_p_i      ),
    .hk_n_i       (hk_n_i      ),
    .exp_p_in_i   (exp_p_in_i  ),
    .trig_cfg_i   (trig_cfg_i  ),
    .scope_trig_i (scope_trig_i),
    .asg_trig_i   (asg_trig_i  ),
    .exp_p_o      (exp_p_o     ),
    .exp_n_o      (exp_n_o     ),
    .trig_ext_o   (trig_ext_o  )
  );

endmodule

`default_nettype wire

/* sim/tb_rp_analog_core.sv */
// Checks outputs at the falling edge; stimulus changes only on rising edges, 400 random cycles
`timescale 1ns/100ps
`default_nettype none

module tb_rp_analog_core import rp_dsp_pkg::*, rp_io_pkg::*; ();

  `include "rp_params.svh"

  localparam int SYNC = `RP_SYNC_STAGES;
  localparam int DMAX = (1 << (`RP_DAC_W-1)) - 1;  // Signed DAC limits
  localparam int DMIN = -DMAX - 1;
  localparam int DP_W = $bits(dac_pair_t);
  localparam int AP_W = $bits(adc_pair_t);
  localparam int BK_W = $bits(exp_bank_t);
  localparam int CF_W = $bits(trig_cfg_t);

  logic adc_clk, rst_n_i, pll_locked_i, digital_loop_i, scope_trig_i, asg_trig_i;
  adc_pair_t adc_raw_i, adc_o;
  dac_pair_t asg_i, pid_i;
  exp_bank_t hk_p_i, hk_n_i, exp_p_o, exp_n_o;
  logic [`RP_EXP_W-1:0] exp_p_in_i;
  trig_cfg_t trig_cfg_i;
  logic core_rstn_o, trig_ext_o;
  dac_code_pair_t dac_o;

  logic [15:0] lfsr;                       // Stimulus LFSR state
  int checks, val_errs, other_errs;
  dac_pair_t asg_q, pid_q;                 // Inputs seen at last falling edge
  adc_pair_t raw_q;
  logic loop_q;
  logic [SYNC-1:0] pin_hist;               // Past P pin 0 levels
  int rstn_run;                            // Falling edges with core reset released
  logic lock_steady;                       // Core reset must stay released

  rp_analog_core UUT (.*);

  always #20 adc_clk = ~adc_clk;  // 40 ns period

  //////////////////////////////
  // Stimulus and references
  //////////////////////////////

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr[0]};
      lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);  // Galois step
    end
    return v;
  endfunction

  function automatic dac_sample_t ref_sat(input dac_sample_t x, input dac_sample_t y);
    int s;
    s = int'(x) + int'(y);
    if (s > DMAX) s = DMAX;
    else if (s < DMIN) s = DMIN;
    return dac_sample_t'(s);
  endfunction

  // Full scale positive maps to code zero
  function automatic dac_code_t ref_code(input dac_sample_t s);
    return dac_code_t'(DMAX - int'(s));
  endfunction

  function automatic adc_sample_t ref_loop(input dac_sample_t s);
    return adc_sample_t'(int'(s) * (1 << `RP_LOOP_SHIFT));
  endfunction

  function automatic exp_bank_t ref_pin_n(input exp_bank_t hk, input trig_cfg_t cfg,
                                          input logic st, input logic at);
    exp_bank_t r;
    r = hk;
    if (cfg.out_en) begin
      r.dat[0] = cfg.src_asg ? at : st;  // Trigger on pin 0
      r.oe[0]  = 1'b1;
    end
    return r;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp_v, input logic [31:0] got_v);
    checks++;
    assert (got_v === exp_v) else begin
      $display("CHECK FAILED %s exp 0x%0h got 0x%0h", name, exp_v, got_v);
      val_errs++;
    end
  endtask

  task automatic lock_pulse_check();
    int t;
    int n;
    t = 0;
    n = 0;
    @(posedge adc_clk);
    pll_locked_i <= 1'b1;
    while (core_rstn_o === 1'b1 && t < 10) begin  // Wait for the pulse start
      @(negedge adc_clk);
      t++;
    end
    if (core_rstn_o !== 1'b0) begin
      $display("ERROR: core reset did not go low after PLL lock");
      other_errs++;
    end
    while (core_rstn_o !== 1'b1 && n < 4 * `RP_RST_MAX) begin
      @(negedge adc_clk);
      n++;
    end
    check_val("core_rstn_o low cycles", `RP_RST_MAX, n);
  endtask

  task automatic drive_random(input logic loop_en, input int cycles);
    for (int k = 0; k < cycles; k++) begin
      @(posedge adc_clk);
      digital_loop_i <= loop_en;
      if (k % 8 == 7) begin  // Sums past both limits
        asg_i <= {14'h1F00, 14'h2100};
        pid_i <= {14'h0F00, 14'h3000};
      end else begin
        asg_i <= DP_W'(rand_bits(DP_W));
        pid_i <= DP_W'(rand_bits(DP_W));
      end
      adc_raw_i    <= AP_W'(rand_bits(AP_W));
      hk_p_i       <= BK_W'(rand_bits(BK_W));
      hk_n_i       <= BK_W'(rand_bits(BK_W));
      exp_p_in_i   <= `RP_EXP_W'(rand_bits(`RP_EXP_W));
      trig_cfg_i   <= CF_W'(rand_bits(CF_W));
      scope_trig_i <= 1'(rand_bits(1));
      asg_trig_i   <= 1'(rand_bits(1));
    end
  endtask

  //////////////////////////////
  // Output comparison
  //////////////////////////////

  always @(negedge adc_clk) begin
    if (rst_n_i === 1'b1) begin
      if (lock_steady)
        check_val("core_rstn_o", 1, 32'(core_rstn_o));  // Lock steady during traffic
      if (core_rstn_o !== 1'b1) begin  // Core reset values
        check_val("adc_o.valid", 0, 32'(adc_o.valid));
        check_val("dac_o", 0, 32'(dac_o));
        check_val("trig_ext_o", 0, 32'(trig_ext_o));
      end else begin
        if (rstn_run >= 1) begin
          check_val("dac_o.a", 32'(ref_code(ref_sat(asg_q.a, pid_q.a))), 32'(dac_o.a));
          check_val("dac_o.b", 32'(ref_code(ref_sat(asg_q.b, pid_q.b))), 32'(dac_o.b));
          if (loop_q) begin
            check_val("adc_o.a", 32'(ref_loop(ref_sat(asg_q.a, pid_q.a))), 32'(adc_o.a));
            check_val("adc_o.b", 32'(ref_loop(ref_sat(asg_q.b, pid_q.b))), 32'(adc_o.b));
            check_val("adc_o.valid", 1, 32'(adc_o.valid));
          end else begin
            check_val("adc_o.a", 32'(raw_q.a), 32'(adc_o.a));
            check_val("adc_o.b", 32'(raw_q.b), 32'(adc_o.b));
            check_val("adc_o.valid", 32'(raw_q.valid), 32'(adc_o.valid));
          end
        end
        if (rstn_run >= SYNC)
          check_val("trig_ext_o", 32'(pin_hist[SYNC-1]), 32'(trig_ext_o));
      end
      check_val("exp_p_o", 32'(hk_p_i), 32'(exp_p_o));  // Pins are combinational
      check_val("exp_n_o", 32'(ref_pin_n(hk_n_i, trig_cfg_i, scope_trig_i, asg_trig_i)),
                32'(exp_n_o));
    end
    rstn_run = (core_rstn_o === 1'b1) ? rstn_run + 1 : 0;
    asg_q    = asg_i;
    pid_q    = pid_i;
    raw_q    = adc_raw_i;
    loop_q   = digital_loop_i;
    pin_hist = {pin_hist[SYNC-2:0], exp_p_in_i[0]};
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int t;
    adc_clk = 1'b0;
    rst_n_i = 1'b0;
    pll_locked_i = 1'b0;
    digital_loop_i = 1'b0;
    adc_raw_i = '0;
    asg_i = '0;
    pid_i = '0;
    hk_p_i = '0;
    hk_n_i = '0;
    exp_p_in_i = '0;
    trig_cfg_i = '0;
    scope_trig_i = 1'b0;
    asg_trig_i = 1'b0;
    lfsr = 16'd6128;
    checks = 0;
    val_errs = 0;
    other_errs = 0;
    rstn_run = 0;
    pin_hist = '0;
    lock_steady = 1'b0;
    repeat (5) @(posedge adc_clk);
    rst_n_i <= 1'b1;
    t = 0;
    while (core_rstn_o !== 1'b1 && t < 10) begin  // No lock yet, no stretch
      @(negedge adc_clk);
      t++;
    end
    if (core_rstn_o !== 1'b1) begin
      $display("ERROR: core reset stayed low after board reset release");
      other_errs++;
    end
    lock_pulse_check();
    @(posedge adc_clk);
    pll_locked_i <= 1'b0;  // Lock loss keeps core running
    repeat (8) begin
      @(negedge adc_clk);
      check_val("core_rstn_o", 1, 32'(core_rstn_o));
    end
    lock_pulse_check();   // Relock gives a full pulse again
    @(posedge adc_clk);
    lock_steady <= 1'b1;  // No more lock edges from here
    drive_random(1'b0, 200);
    drive_random(1'b1, 200);
    repeat (SYNC + 1) @(negedge adc_clk);
    $display("checks %0d, value errors %0d, other errors %0d", checks, val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+design
design/rp_dsp_pkg.sv
design/rp_io_pkg.sv
design/reset_seq.sv
design/adc_input_stage.sv
design/dac_mixer.sv
design/exp_pin_mux.sv
design/rp_analog_core.sv
sim/tb_rp_analog_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rp_analog_core
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= PASS: all tests

SRCS := $(shell grep -v '^+' $(FLIST)) design/rp_params.svh

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
